// File: rtl/gc_pkg.sv
// Bus widths, address map, region enum and the bus structs of the fabric
`default_nettype none

package gc_pkg;

  ////////////////////////////////////////
  // Widths

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned SelWidth  = DataWidth / 8;

  ////////////////////////////////////////
  // Address map

  localparam logic [AddrWidth-1:0] L1Base    = 32'h4000_0000;
  localparam logic [AddrWidth-1:0] L1Size    = 32'h0000_0400;
  localparam logic [AddrWidth-1:0] ClintBase = 32'h1000_0000;
  localparam logic [AddrWidth-1:0] ClintSize = 32'h0001_0000;
  localparam logic [AddrWidth-1:0] PerfBase  = ClintBase + ClintSize;
  localparam logic [AddrWidth-1:0] PerfSize  = 32'h0000_0100;

  // CLINT register offsets, 64-bit registers are low word first
  localparam logic [15:0] ClintMsipOffset     = 16'h0000;
  localparam logic [15:0] ClintMtimecmpOffset = 16'h4000;
  localparam logic [15:0] ClintMtimeOffset    = 16'hBFF8;

  typedef enum logic [1:0] {
    REGION_ERROR,
    REGION_L1,
    REGION_CLINT,
    REGION_PERF
  } region_e;

  localparam int unsigned RegionCount = 4;

  ////////////////////////////////////////
  // Bus structs

  // Wishbone classic, driven by the master
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [AddrWidth-1:0] adr;
    logic [DataWidth-1:0] dat;
    logic [SelWidth-1:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic                 ack;
    logic                 err;
    logic [DataWidth-1:0] dat;
  } wb_rsp_t;

  // Controller to a single target
  typedef struct packed {
    logic                 valid;
    logic                 we;
    logic [15:0]          offset;
    logic [DataWidth-1:0] wdata;
    logic [SelWidth-1:0]  sel;
  } tgt_req_t;

  // One completed access
  typedef struct packed {
    logic    valid;
    logic    we;
    region_e region;
  } perf_event_t;

endpackage

`default_nettype wire

// File: rtl/gc_bus_ctrl.sv
// Bus controller with address decode, access FSM, response mux and perf events
`timescale 1ns/1ps
`default_nettype none

module gc_bus_ctrl (
  input  wire logic                                clk_i,
  input  wire logic                                rst_i,
  input  wire gc_pkg::wb_req_t                     wb_req_i,
  output gc_pkg::wb_rsp_t                          wb_rsp_o,
  output gc_pkg::tgt_req_t                         l1_req_o,
  output gc_pkg::tgt_req_t                         clint_req_o,
  output gc_pkg::tgt_req_t                         perf_req_o,
  input  wire logic        [gc_pkg::DataWidth-1:0] l1_rdata_i,
  input  wire logic        [gc_pkg::DataWidth-1:0] clint_rdata_i,
  input  wire logic        [gc_pkg::DataWidth-1:0] perf_rdata_i,
  output gc_pkg::perf_event_t                      perf_event_o
);

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    WAIT,
    RESPOND
  } state_e;

  state_e                         state_q;
  gc_pkg::region_e                region_d, region_q;
  logic [gc_pkg::AddrWidth-1:0]   base_d;
  logic [gc_pkg::AddrWidth-1:0]   offset_full;
  gc_pkg::tgt_req_t               tgt_q;
  logic                           tgt_valid_q;
  logic                           ack_q, err_q;
  logic [gc_pkg::DataWidth-1:0]   rdat_q;
  logic                           evt_valid_q;
  logic                           accept;

  ////////////////////////////////////////
  // Address decode

  always_comb begin
    region_d = gc_pkg::REGION_ERROR;
    base_d   = '0;
    if (wb_req_i.adr >= gc_pkg::L1Base && wb_req_i.adr < gc_pkg::L1Base + gc_pkg::L1Size) begin
      region_d = gc_pkg::REGION_L1;
      base_d   = gc_pkg::L1Base;
    end else if (wb_req_i.adr >= gc_pkg::ClintBase &&
                 wb_req_i.adr < gc_pkg::ClintBase + gc_pkg::ClintSize) begin
      region_d = gc_pkg::REGION_CLINT;
      base_d   = gc_pkg::ClintBase;
    end else if (wb_req_i.adr >= gc_pkg::PerfBase &&
                 wb_req_i.adr < gc_pkg::PerfBase + gc_pkg::PerfSize) begin
      region_d = gc_pkg::REGION_PERF;
      base_d   = gc_pkg::PerfBase;
    end
  end

  assign offset_full = wb_req_i.adr - base_d;

  // Hold off while the previous response is still on the port
  assign accept = (state_q == IDLE) && wb_req_i.cyc && wb_req_i.stb && !ack_q && !err_q;

  ////////////////////////////////////////
  // Access sequencing

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q     <= IDLE;
      tgt_valid_q <= 1'b0;
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      evt_valid_q <= 1'b0;
    end else begin
      tgt_valid_q <= 1'b0;
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      evt_valid_q <= 1'b0;
      case (state_q)
        IDLE:    if (accept) state_q <= ACCESS;
        ACCESS: begin
          tgt_valid_q <= (region_q != gc_pkg::REGION_ERROR);
          state_q     <= WAIT;
        end
        WAIT:    state_q <= RESPOND;
        RESPOND: begin
          // Dropped cycle still completes, only the response is withheld
          ack_q       <= wb_req_i.cyc && (region_q != gc_pkg::REGION_ERROR);
          err_q       <= wb_req_i.cyc && (region_q == gc_pkg::REGION_ERROR);
          evt_valid_q <= 1'b1;
          state_q     <= IDLE;
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      region_q     <= region_d;
      tgt_q.valid  <= 1'b0;
      tgt_q.we     <= wb_req_i.we;
      tgt_q.offset <= offset_full[15:0];
      tgt_q.wdata  <= wb_req_i.dat;
      tgt_q.sel    <= wb_req_i.sel;
    end
    if (state_q == RESPOND) begin
      case (region_q)
        gc_pkg::REGION_L1:    rdat_q <= l1_rdata_i;
        gc_pkg::REGION_CLINT: rdat_q <= clint_rdata_i;
        gc_pkg::REGION_PERF:  rdat_q <= perf_rdata_i;
        default:              rdat_q <= '0;
      endcase
    end
  end

  ////////////////////////////////////////
  // Outputs

  always_comb begin
    l1_req_o          = tgt_q;
    l1_req_o.valid    = tgt_valid_q && (region_q == gc_pkg::REGION_L1);
    clint_req_o       = tgt_q;
    clint_req_o.valid = tgt_valid_q && (region_q == gc_pkg::REGION_CLINT);
    perf_req_o        = tgt_q;
    perf_req_o.valid  = tgt_valid_q && (region_q == gc_pkg::REGION_PERF);
  end

  assign wb_rsp_o     = '{ack: ack_q, err: err_q, dat: rdat_q};
  assign perf_event_o = '{valid: evt_valid_q, we: tgt_q.we, region: region_q};

  a_ack_err_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
    !(ack_q && err_q))
    else $error("gc_bus_ctrl: ack and err high together");

  a_rsp_single_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    (ack_q || err_q) |=> !(ack_q || err_q))
    else $error("gc_bus_ctrl: response held for more than one cycle");

endmodule

`default_nettype wire

// File: rtl/gc_l1_mem.sv
// Word-interleaved banked L1 scratchpad with byte enables
`timescale 1ns/1ps
`default_nettype none

module gc_l1_mem #(
  parameter int unsigned L1BankCount    = 2,
  parameter int unsigned L1WordsPerBank = 128
) (
  input  wire logic                                clk_i,
  input  wire logic                                rst_i,
  input  wire gc_pkg::tgt_req_t                    req_i,
  output logic             [gc_pkg::DataWidth-1:0] rdata_o
);

  localparam int unsigned WordBits = $clog2(gc_pkg::L1Size) - 2;
  localparam int unsigned BankBits = (L1BankCount > 1) ? $clog2(L1BankCount) : 1;
  localparam int unsigned RowBits  = (L1WordsPerBank > 1) ? $clog2(L1WordsPerBank) : 1;

  logic [WordBits-1:0]          word_idx;
  logic [BankBits-1:0]          bank_sel;
  logic [RowBits-1:0]           row_sel;
  logic [BankBits-1:0]          rd_bank_q;
  logic [gc_pkg::DataWidth-1:0] bank_rdata [L1BankCount];

  // Low word bits interleave across banks
  assign word_idx = req_i.offset[WordBits+1:2];
  assign bank_sel = BankBits'(32'(word_idx) % L1BankCount);
  assign row_sel  = RowBits'(32'(word_idx) / L1BankCount);

  for (genvar b = 0; b < L1BankCount; b++) begin : gen_bank
    logic [gc_pkg::DataWidth-1:0] mem_q [L1WordsPerBank];

    always_ff @(posedge clk_i) begin
      if (req_i.valid && (bank_sel == BankBits'(b))) begin
        if (req_i.we) begin
          for (int i = 0; i < gc_pkg::SelWidth; i++) begin
            if (req_i.sel[i]) begin
              mem_q[row_sel][i*8 +: 8] <= req_i.wdata[i*8 +: 8];
            end
          end
        end else begin
          bank_rdata[b] <= mem_q[row_sel];
        end
      end
    end
  end

  // Remember which bank answered the last read
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_bank_q <= '0;
    end else if (req_i.valid && !req_i.we) begin
      rd_bank_q <= bank_sel;
    end
  end

  assign rdata_o = bank_rdata[rd_bank_q];

  a_offset_in_l1: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.valid |-> (gc_pkg::AddrWidth'(req_i.offset) < gc_pkg::L1Size))
    else $error("gc_l1_mem: offset 0x%h outside L1", req_i.offset);

endmodule

`default_nettype wire

// File: rtl/gc_clint.sv
// CLINT with machine timer, timer compare, software interrupt bit and register access
`timescale 1ns/1ps
`default_nettype none

module gc_clint (
  input  wire logic                                clk_i,
  input  wire logic                                rst_i,
  input  wire gc_pkg::tgt_req_t                    req_i,
  output logic             [gc_pkg::DataWidth-1:0] rdata_o,
  output logic                                     timer_irq_o,
  output logic                                     ipi_o
);

  localparam logic [15:0] MtimecmpLoOffset = gc_pkg::ClintMtimecmpOffset;
  localparam logic [15:0] MtimecmpHiOffset = gc_pkg::ClintMtimecmpOffset + 16'h4;
  localparam logic [15:0] MtimeLoOffset    = gc_pkg::ClintMtimeOffset;
  localparam logic [15:0] MtimeHiOffset    = gc_pkg::ClintMtimeOffset + 16'h4;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic        msip_q;
  logic        wr_en;
  logic        rd_en;

  assign wr_en = req_i.valid && req_i.we;
  assign rd_en = req_i.valid && !req_i.we;

  ////////////////////////////////////////
  // Timer and interrupt state

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      msip_q      <= 1'b0;
      timer_irq_o <= 1'b0;
    end else begin
      // Free running, not writable from the bus
      mtime_q     <= mtime_q + 64'd1;
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      if (wr_en) begin
        case (req_i.offset)
          gc_pkg::ClintMsipOffset: begin
            if (req_i.sel[0]) begin
              msip_q <= req_i.wdata[0];
            end
          end
          MtimecmpLoOffset: begin
            for (int i = 0; i < gc_pkg::SelWidth; i++) begin
              if (req_i.sel[i]) begin
                mtimecmp_q[i*8 +: 8] <= req_i.wdata[i*8 +: 8];
              end
            end
          end
          MtimecmpHiOffset: begin
            for (int i = 0; i < gc_pkg::SelWidth; i++) begin
              if (req_i.sel[i]) begin
                mtimecmp_q[32 + i*8 +: 8] <= req_i.wdata[i*8 +: 8];
              end
            end
          end
          default: ;
        endcase
      end
    end
  end

  ////////////////////////////////////////
  // Register read

  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      case (req_i.offset)
        gc_pkg::ClintMsipOffset: rdata_o <= {31'd0, msip_q};
        MtimecmpLoOffset:        rdata_o <= mtimecmp_q[31:0];
        MtimecmpHiOffset:        rdata_o <= mtimecmp_q[63:32];
        MtimeLoOffset:           rdata_o <= mtime_q[31:0];
        MtimeHiOffset:           rdata_o <= mtime_q[63:32];
        default:                 rdata_o <= '0;
      endcase
    end
  end

  assign ipi_o = msip_q;

endmodule

`default_nettype wire

// File: rtl/gc_perf_cntrs.sv
// Per-region read and write access counters with register access
`timescale 1ns/1ps
`default_nettype none

module gc_perf_cntrs (
  input  wire logic                                clk_i,
  input  wire logic                                rst_i,
  input  wire gc_pkg::tgt_req_t                    req_i,
  output logic             [gc_pkg::DataWidth-1:0] rdata_o,
  input  wire gc_pkg::perf_event_t                 event_i
);

  localparam int unsigned CounterCount = gc_pkg::RegionCount * 2;
  localparam int unsigned IdxBits      = $clog2(CounterCount);

  logic [gc_pkg::DataWidth-1:0] cnt_q [CounterCount];
  logic [IdxBits-1:0]           bus_idx;
  logic [IdxBits-1:0]           evt_idx;
  logic                         bus_hit;
  logic                         clr_pend_q;
  logic [IdxBits-1:0]           clr_idx_q;

  // Counter k at word offset k, nothing mapped above
  assign bus_idx = req_i.offset[IdxBits+1:2];
  assign bus_hit = (req_i.offset[15:IdxBits+2] == '0);
  assign evt_idx = {event_i.region, event_i.we};

  ////////////////////////////////////////
  // Counters

  // Clear lands together with the event of the clearing write itself
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      clr_pend_q <= 1'b0;
      for (int k = 0; k < CounterCount; k++) begin
        cnt_q[k] <= '0;
      end
    end else begin
      if (req_i.valid && req_i.we && bus_hit) begin
        clr_pend_q <= 1'b1;
      end else if (event_i.valid) begin
        clr_pend_q <= 1'b0;
      end
      for (int k = 0; k < CounterCount; k++) begin
        if (event_i.valid && clr_pend_q && (clr_idx_q == IdxBits'(k))) begin
          cnt_q[k] <= '0;
        end else if (event_i.valid && (evt_idx == IdxBits'(k))) begin
          cnt_q[k] <= cnt_q[k] + gc_pkg::DataWidth'(1);
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid && req_i.we && bus_hit) begin
      clr_idx_q <= bus_idx;
    end
    if (req_i.valid && !req_i.we) begin
      rdata_o <= bus_hit ? cnt_q[bus_idx] : '0;
    end
  end

endmodule

`default_nettype wire

// File: rtl/gc_system.sv
// System top with bus controller, L1 scratchpad, CLINT and perf counters
`timescale 1ns/1ps
`default_nettype none

module gc_system #(
  parameter int unsigned L1BankCount = 2
) (
  input  wire logic            clk_i,
  input  wire logic            rst_i,
  input  wire gc_pkg::wb_req_t wb_req_i,
  output gc_pkg::wb_rsp_t      wb_rsp_o,
  output logic                 timer_irq_o,
  output logic                 ipi_o
);

  localparam int unsigned L1WordsPerBank = gc_pkg::L1Size / 4 / L1BankCount;

  gc_pkg::tgt_req_t             l1_req, clint_req, perf_req;
  logic [gc_pkg::DataWidth-1:0] l1_rdata, clint_rdata, perf_rdata;
  gc_pkg::perf_event_t          perf_event;

  ////////////////////////////////////////
  // Bus controller

  gc_bus_ctrl u_gc_bus_ctrl (
    .clk_i         ( clk_i       ),
    .rst_i         ( rst_i       ),
    .wb_req_i      ( wb_req_i    ),
    .wb_rsp_o      ( wb_rsp_o    ),
    .l1_req_o      ( l1_req      ),
    .clint_req_o   ( clint_req   ),
    .perf_req_o    ( perf_req    ),
    .l1_rdata_i    ( l1_rdata    ),
    .clint_rdata_i ( clint_rdata ),
    .perf_rdata_i  ( perf_rdata  ),
    .perf_event_o  ( perf_event  )
  );

  ////////////////////////////////////////
  // Targets

  gc_l1_mem #(
    .L1BankCount    ( L1BankCount    ),
    .L1WordsPerBank ( L1WordsPerBank )
  ) u_gc_l1_mem (
    .clk_i   ( clk_i    ),
    .rst_i   ( rst_i    ),
    .req_i   ( l1_req   ),
    .rdata_o ( l1_rdata )
  );

  gc_clint u_gc_clint (
    .clk_i       ( clk_i       ),
    .rst_i       ( rst_i       ),
    .req_i       ( clint_req   ),
    .rdata_o     ( clint_rdata ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  gc_perf_cntrs u_gc_perf_cntrs (
    .clk_i   ( clk_i      ),
    .rst_i   ( rst_i      ),
    .req_i   ( perf_req   ),
    .rdata_o ( perf_rdata ),
    .event_i ( perf_event )
  );

  if (L1BankCount != 2**$clog2(L1BankCount)) begin : gen_bank_check
    $error("gc_system: L1BankCount must be a power of two");
  end

endmodule

`default_nettype wire

// File: testbench/tb_clk_gen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned Period      = 10,
  parameter int unsigned ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_o = 1'b1;
    repeat (ResetCycles) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: testbench/tb_gc_system.sv
// Testbench for the fabric with stimulus, reference model, assertions and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_gc_system;

  localparam int unsigned Period      = 10;
  localparam int unsigned MaxTxns     = 400;
  localparam int unsigned TimerMargin = 500;
  localparam int unsigned L1Words     = 32;

  logic                clk;
  logic                rst;
  gc_pkg::wb_req_t     wb_req;
  gc_pkg::wb_rsp_t     wb_rsp;
  logic                timer_irq;
  logic                ipi;
  logic                exp_err;
  logic                chk_rd;
  logic [31:0]         exp_dat;
  logic [31:0]         last_rdata;
  logic [7:0]          l1_shadow [1024];
  int unsigned         perf_shadow [8];
  logic                msip_model;
  int                  error_count;
  int                  txn_count;

  tb_clk_gen #(
    .Period      ( Period ),
    .ResetCycles ( 2      )
  ) u_tb_clk_gen (
    .clk_o ( clk ),
    .rst_o ( rst )
  );

  gc_system #(
    .L1BankCount ( 2 )
  ) u_gc_system (
    .clk_i       ( clk       ),
    .rst_i       ( rst       ),
    .wb_req_i    ( wb_req    ),
    .wb_rsp_o    ( wb_rsp    ),
    .timer_irq_o ( timer_irq ),
    .ipi_o       ( ipi       )
  );

  ////////////////////////////////////////
  // Assertions

  // Accepted on the first edge with stb high, response 3 edges later
  a_rsp_timing: assert property (@(posedge clk) disable iff (rst)
    (wb_rsp.ack || wb_rsp.err) |-> ($past(wb_req.stb, 4) && !$past(wb_req.stb, 5)))
    else begin
      error_count++;
      $display("Response did not start 3 cycles after acceptance");
    end

  a_rsp_single: assert property (@(posedge clk) disable iff (rst)
    (wb_rsp.ack || wb_rsp.err) |=> !(wb_rsp.ack || wb_rsp.err))
    else begin
      error_count++;
      $display("Response stayed high for more than one cycle");
    end

  a_no_overlap: assert property (@(posedge clk) disable iff (rst)
    !(wb_rsp.ack && wb_rsp.err))
    else begin
      error_count++;
      $display("ack and err were high in the same cycle");
    end

  a_rsp_kind: assert property (@(posedge clk) disable iff (rst)
    (wb_rsp.ack || wb_rsp.err) |-> (wb_rsp.err == exp_err))
    else begin
      error_count++;
      $display("Error: wb_rsp_o.err expected 0x%h got 0x%h", $sampled(exp_err),
               $sampled(wb_rsp.err));
    end

  a_rsp_data: assert property (@(posedge clk) disable iff (rst)
    (wb_rsp.ack && chk_rd) |-> (wb_rsp.dat == exp_dat))
    else begin
      error_count++;
      $display("Error: wb_rsp_o.dat expected 0x%h got 0x%h", $sampled(exp_dat),
               $sampled(wb_rsp.dat));
    end

  ////////////////////////////////////////
  // Reference model and bus access

  function automatic int region_of(input logic [31:0] adr, output logic [15:0] off);
    logic [31:0] rel;
    int          region;
    region = 0;
    rel    = '0;
    if (adr >= gc_pkg::L1Base && adr < gc_pkg::L1Base + gc_pkg::L1Size) begin
      region = 1;
      rel    = adr - gc_pkg::L1Base;
    end else if (adr >= gc_pkg::ClintBase && adr < gc_pkg::ClintBase + gc_pkg::ClintSize) begin
      region = 2;
      rel    = adr - gc_pkg::ClintBase;
    end else if (adr >= gc_pkg::PerfBase && adr < gc_pkg::PerfBase + gc_pkg::PerfSize) begin
      region = 3;
      rel    = adr - gc_pkg::PerfBase;
    end
    off = rel[15:0];
    return region;
  endfunction

  task automatic access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                        input logic [3:0] sel);
    int          region;
    logic [15:0] off;
    logic [31:0] exp;
    logic        chk;
    region = region_of(adr, off);
    exp    = '0;
    chk    = 1'b0;
    if (!we) begin
      if (region == 1) begin
        for (int b = 0; b < 4; b++) begin
          exp[b*8 +: 8] = l1_shadow[int'(off) + b];
        end
        chk = 1'b1;
      end else if (region == 3) begin
        exp = (off < 16'h20) ? perf_shadow[off[4:2]] : '0;
        chk = 1'b1;
      end else if (region == 2 && off == gc_pkg::ClintMsipOffset) begin
        exp = {31'd0, msip_model};
        chk = 1'b1;
      end
    end
    @(posedge clk);
    wb_req  <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat, sel: sel};
    exp_err <= (region == 0);
    chk_rd  <= chk;
    exp_dat <= exp;
    do @(negedge clk); while (!(wb_rsp.ack || wb_rsp.err));
    last_rdata = wb_rsp.dat;
    @(posedge clk);
    wb_req.cyc <= 1'b0;
    wb_req.stb <= 1'b0;
    // Update the model after the access completed
    if (we && region == 1) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) l1_shadow[int'(off) + b] = dat[b*8 +: 8];
      end
    end
    if (we && region == 2 && off == gc_pkg::ClintMsipOffset && sel[0]) begin
      msip_model = dat[0];
    end
    perf_shadow[region*2 + int'(we)]++;
    if (we && region == 3 && off < 16'h20) begin
      perf_shadow[off[4:2]] = 0;
    end
    txn_count++;
  endtask

  ////////////////////////////////////////
  // Stimulus

  initial begin
    logic [31:0] t1;
    logic [31:0] t2;
    logic        irq_seen;
    void'($urandom(32'h763dd203));
    wb_req      = '0;
    exp_err     = 1'b0;
    chk_rd      = 1'b0;
    exp_dat     = '0;
    msip_model  = 1'b0;
    error_count = 0;
    txn_count   = 0;
    for (int k = 0; k < 8; k++) perf_shadow[k] = 0;
    do @(posedge clk); while (rst);
    @(negedge clk);
    assert (!wb_rsp.ack && !wb_rsp.err && !ipi && !timer_irq)
      else begin
        error_count++;
        $display("Outputs were not low after reset");
      end

    // L1 fill, partial writes across banks, read back
    for (int i = 0; i < L1Words; i++) access(1'b1, gc_pkg::L1Base + 32'(i * 4), $urandom, 4'hf);
    repeat (48) access(1'b1, gc_pkg::L1Base + 32'(($urandom % L1Words) * 4), $urandom,
                       4'($urandom));
    for (int i = 0; i < L1Words; i++) access(1'b0, gc_pkg::L1Base + 32'(i * 4), '0, 4'hf);

    // Unmapped accesses
    access(1'b0, 32'h1001_0100, '0, 4'hf);
    access(1'b1, 32'h4000_0400, $urandom, 4'hf);
    access(1'b0, 32'h0000_0000, '0, 4'hf);
    access(1'b1, 32'h2000_0000, $urandom, 4'hf);
    repeat (8) access(1'($urandom), {1'b1, 31'($urandom)}, $urandom, 4'hf);

    // Software interrupt
    access(1'b1, gc_pkg::ClintBase + 32'(gc_pkg::ClintMsipOffset), 32'd1, 4'hf);
    assert (ipi) else begin
      error_count++;
      $display("Error: ipi_o expected 0x1 got 0x%h", ipi);
    end
    access(1'b0, gc_pkg::ClintBase + 32'(gc_pkg::ClintMsipOffset), '0, 4'hf);
    access(1'b1, gc_pkg::ClintBase + 32'(gc_pkg::ClintMsipOffset), 32'd0, 4'hf);
    assert (!ipi) else begin
      error_count++;
      $display("Error: ipi_o expected 0x0 got 0x%h", ipi);
    end

    // Machine timer
    access(1'b0, gc_pkg::ClintBase + 32'(gc_pkg::ClintMtimeOffset), '0, 4'hf);
    t1 = last_rdata;
    access(1'b0, gc_pkg::ClintBase + 32'(gc_pkg::ClintMtimeOffset), '0, 4'hf);
    t2 = last_rdata;
    assert (t2 > t1) else begin
      error_count++;
      $display("mtime did not increase between two reads (0x%h then 0x%h)", t1, t2);
    end
    access(1'b1, gc_pkg::ClintBase + 32'(gc_pkg::ClintMtimecmpOffset), t2 + 32'd40, 4'hf);
    access(1'b1, gc_pkg::ClintBase + 32'(gc_pkg::ClintMtimecmpOffset) + 32'd4, '0, 4'hf);
    irq_seen = 1'b0;
    for (int c = 0; c < TimerMargin && !irq_seen; c++) begin
      @(negedge clk);
      irq_seen = timer_irq;
    end
    assert (irq_seen) else begin
      error_count++;
      $display("Timer interrupt never rose after mtimecmp was set");
    end
    access(1'b1, gc_pkg::ClintBase + 32'(gc_pkg::ClintMtimecmpOffset) + 32'd4, '1, 4'hf);
    assert (!timer_irq) else begin
      error_count++;
      $display("Error: timer_irq_o expected 0x0 got 0x%h", timer_irq);
    end

    // Perf counters after a random mix
    repeat (40) begin
      case ($urandom % 4)
        0: access(1'b0, gc_pkg::L1Base + 32'(($urandom % L1Words) * 4), '0, 4'hf);
        1: access(1'b1, gc_pkg::L1Base + 32'(($urandom % L1Words) * 4), $urandom, 4'($urandom));
        2: access(1'b0, gc_pkg::ClintBase + 32'(gc_pkg::ClintMsipOffset), '0, 4'hf);
        default: access(1'b0, {1'b1, 31'($urandom)}, '0, 4'hf);
      endcase
    end
    for (int k = 0; k < 8; k++) access(1'b0, gc_pkg::PerfBase + 32'(k * 4), '0, 4'hf);
    // Clear the L1 read counter, then count three more
    access(1'b1, gc_pkg::PerfBase + 32'd8, '0, 4'hf);
    repeat (3) access(1'b0, gc_pkg::L1Base + 32'(($urandom % L1Words) * 4), '0, 4'hf);
    access(1'b0, gc_pkg::PerfBase + 32'd8, '0, 4'hf);

    repeat (2) @(posedge clk);
    $display("%0d transactions, %0d errors", txn_count, error_count);
    if (error_count == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Watchdog sized from the transaction budget and the timer wait
  initial begin
    #(Period * (MaxTxns * 8 + TimerMargin + 20));
    $display("Watchdog expired before the tests completed");
    $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: gc_system.f
rtl/gc_pkg.sv
rtl/gc_bus_ctrl.sv
rtl/gc_l1_mem.sv
rtl/gc_clint.sv
rtl/gc_perf_cntrs.sv
rtl/gc_system.sv
testbench/tb_clk_gen.sv
testbench/tb_gc_system.sv

// File: Makefile
# Verilator build and run for the gc_system testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f gc_system.f --top-module tb_gc_system -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
